//--- common/cmd_desc_if.sv
`timescale 1ns/1ps

interface cmd_desc_if;
    import csb_pkg::*;

    logic             desc_valid;  // One cycle, fields stable from here
    op_type_e         op_type;
    logic             padding;
    logic [7:0]       stride_1;    // Line size
    logic [15:0]      stride_2;    // Surface size
    logic [15:0]      i_channel_size;
    logic [15:0]      o_channel_size;
    logic [7:0]       i_kernel_size;
    logic [7:0]       o_kernel_size;
    logic [15:0]      op_num;
    logic [CMD_W-1:0] weight_addr;
    logic [CMD_W-1:0] data_addr;
    logic [CMD_W-1:0] wb_addr;

    modport source (output desc_valid, op_type, padding, stride_1, stride_2, i_channel_size,
                    o_channel_size, i_kernel_size, o_kernel_size, op_num, weight_addr,
                    data_addr, wb_addr);
    modport sink (input desc_valid, op_type, padding, stride_1, stride_2, i_channel_size,
                  o_channel_size, i_kernel_size, o_kernel_size, op_num, weight_addr,
                  data_addr, wb_addr);
    modport mon (input op_type);  // Port controller only needs the op

endinterface

//--- common/csb_pkg.sv
package csb_pkg;

    // Command layout, one layer command is six FIFO words
    localparam int CMD_WORDS = 6;
    localparam int CMD_W     = 32;
    localparam int CMD_CNT_W = $clog2(CMD_WORDS);  // Word counter width in the parser

    // Word positions inside a command
    localparam int W_OPCFG  = 0;  // op_type, padding, stride_1, stride_2
    localparam int W_CHAN   = 1;  // Input / output channel sizes
    localparam int W_KERN   = 2;  // Kernel sizes and op_num
    localparam int W_WADDR  = 3;  // Weight start address
    localparam int W_DADDR  = 4;  // Data start address
    localparam int W_WBADDR = 5;  // Write-back address, last word

    // Command FIFO
    localparam int FIFO_DEPTH = 32;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // Channel progress and command count
    localparam int CNT_W   = 16;
    localparam int CH_STEP = 16;  // Output channels per engine valid

    // Register map
    localparam logic [1:0] REG_CTRL      = 2'd0;  // bit0 start, bit1 irq clear
    localparam logic [1:0] REG_CMD_COUNT = 2'd1;

    typedef enum logic [2:0] {
        OP_IDLE         = 3'd0,
        OP_CONV1X1      = 3'd1,
        OP_CONV3X3      = 3'd2,
        OP_CONV3X3_1X1  = 3'd3,  // 3x3 with padding, then 1x1
        OP_MAXPOOL3X3   = 3'd4,
        OP_AVEPOOL13X13 = 3'd5
    } op_type_e;

    typedef enum logic [2:0] {
        S_IDLE    = 3'd0,
        S_COLLECT = 3'd1,  // Parser pulling words
        S_ISSUE   = 3'd2,
        S_WAIT_OP = 3'd3,  // Counting engine valids
        S_FINISH  = 3'd4
    } csb_state_e;

endpackage

//--- csb/cmd_fifo.sv
`timescale 1ns/1ps

module cmd_fifo (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_wr,
    input  logic [csb_pkg::CMD_W-1:0] i_wdata,
    input  logic                      i_rd,
    output logic [csb_pkg::CMD_W-1:0] o_rdata,
    output logic                      o_empty,
    output logic                      o_full
);
    import csb_pkg::*;

    logic [CMD_W-1:0]   mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;   // Occupancy, one extra bit for full
    logic               do_wr;
    logic               do_rd;

    assign o_full  = count == (FIFO_AW+1)'(FIFO_DEPTH);
    assign o_empty = count == '0;
    assign do_wr   = i_wr & ~o_full;  // Host writes to a full FIFO are lost
    assign do_rd   = i_rd & ~o_empty;
    assign o_rdata = mem[rd_ptr];     // Head word always visible

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= i_wdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;  // Power-of-two depth, wraps by itself
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // Both or neither
            endcase
        end
    end

endmodule

//--- csb/cmd_parser.sv
`timescale 1ns/1ps

module cmd_parser (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_collect,
    input  logic [csb_pkg::CMD_W-1:0] i_fifo_rdata,
    input  logic                      i_fifo_empty,
    output logic                      o_fifo_rd,
    cmd_desc_if.source                desc
);
    import csb_pkg::*;

    logic [CMD_CNT_W-1:0] word_cnt;                  // Position inside the command
    logic [CMD_W-1:0]     stage_q [CMD_WORDS-1];     // First five words, held until commit
    logic                 last_word;

    // No pop in the desc_valid cycle, the sequencer drops collect on that edge
    assign o_fifo_rd = i_collect & ~i_fifo_empty & ~desc.desc_valid;
    assign last_word = word_cnt == CMD_CNT_W'(CMD_WORDS - 1);

    always_ff @(posedge clk) begin
        if (o_fifo_rd && !last_word) stage_q[word_cnt] <= i_fifo_rdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt            <= '0;
            desc.desc_valid     <= 1'b0;
            desc.op_type        <= OP_IDLE;
            desc.padding        <= 1'b0;
            desc.stride_1       <= '0;
            desc.stride_2       <= '0;
            desc.i_channel_size <= '0;
            desc.o_channel_size <= '0;
            desc.i_kernel_size  <= '0;
            desc.o_kernel_size  <= '0;
            desc.op_num         <= '0;
            desc.weight_addr    <= '0;
            desc.data_addr      <= '0;
            desc.wb_addr        <= '0;
        end else begin
            desc.desc_valid <= o_fifo_rd & last_word;
            if (o_fifo_rd) begin
                word_cnt <= last_word ? '0 : word_cnt + 1'b1;
                if (last_word) begin  // Commit the whole descriptor at once
                    desc.op_type        <= op_type_e'(stage_q[W_OPCFG][2:0]);
                    desc.padding        <= stage_q[W_OPCFG][3];
                    desc.stride_1       <= stage_q[W_OPCFG][15:8];
                    desc.stride_2       <= stage_q[W_OPCFG][31:16];
                    desc.i_channel_size <= stage_q[W_CHAN][15:0];
                    desc.o_channel_size <= stage_q[W_CHAN][31:16];
                    desc.i_kernel_size  <= stage_q[W_KERN][7:0];
                    desc.o_kernel_size  <= stage_q[W_KERN][15:8];
                    desc.op_num         <= stage_q[W_KERN][31:16];
                    desc.weight_addr    <= stage_q[W_WADDR];
                    desc.data_addr      <= stage_q[W_DADDR];
                    desc.wb_addr        <= i_fifo_rdata;  // Sixth word straight from FIFO
                end
            end
        end
    end

endmodule

//--- csb/csb_sequencer.sv
`timescale 1ns/1ps

module csb_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_start,
    input  logic                      i_irq_clr,
    input  logic [csb_pkg::CNT_W-1:0] i_cmd_count,
    output logic                      o_collect,
    cmd_desc_if.sink                  desc,
    input  logic                      i_conv_valid,
    input  logic                      i_maxpool_valid,
    input  logic                      i_avepool_valid,
    output logic                      o_conv_ready,
    output logic                      o_maxpool_ready,
    output logic                      o_avepool_ready,
    output logic                      o_op_start,
    output logic                      o_op_done,
    output logic                      o_op_run,
    output logic                      o_irq
);
    import csb_pkg::*;

    csb_state_e       state;
    logic [CNT_W-1:0] cmd_done;    // Commands executed in this batch
    logic [CNT_W:0]   prog;        // Output channels done, extra bit against wrap
    logic [CNT_W:0]   prog_next;
    logic             sel_conv;
    logic             sel_max;
    logic             sel_ave;
    logic             op_known;
    logic             eng_valid;   // Valid from the engine that is ready
    logic             ch_done;
    logic             cmd_step;    // Current command finished or skipped
    logic             last_cmd;

    assign sel_conv  = desc.op_type inside {OP_CONV1X1, OP_CONV3X3, OP_CONV3X3_1X1};
    assign sel_max   = desc.op_type == OP_MAXPOOL3X3;
    assign sel_ave   = desc.op_type == OP_AVEPOOL13X13;
    assign op_known  = sel_conv | sel_max | sel_ave;  // 0, 6, 7 are skipped
    assign eng_valid = (o_conv_ready & i_conv_valid) | (o_maxpool_ready & i_maxpool_valid)
                     | (o_avepool_ready & i_avepool_valid);
    assign prog_next = prog + (CNT_W+1)'(CH_STEP);
    assign ch_done   = prog_next >= {1'b0, desc.o_channel_size};  // Reach or pass
    assign cmd_step  = (state == S_ISSUE && !op_known)
                     | (state == S_WAIT_OP && eng_valid && ch_done);
    assign last_cmd  = (cmd_done + 1'b1) >= i_cmd_count;
    assign o_collect = state == S_COLLECT;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= S_IDLE;
            cmd_done        <= '0;
            prog            <= '0;
            o_conv_ready    <= 1'b0;
            o_maxpool_ready <= 1'b0;
            o_avepool_ready <= 1'b0;
            o_op_start      <= 1'b0;
            o_op_done       <= 1'b0;
            o_op_run        <= 1'b0;
            o_irq           <= 1'b0;
        end else begin
            o_op_start <= 1'b0;  // Pulses by default low
            o_op_done  <= 1'b0;
            case (state)
                S_IDLE: if (i_start) begin
                    cmd_done <= '0;
                    o_op_run <= 1'b1;
                    state    <= S_COLLECT;
                end
                S_COLLECT: if (desc.desc_valid) state <= S_ISSUE;
                S_ISSUE: begin
                    prog <= '0;
                    if (op_known) begin
                        o_conv_ready    <= sel_conv;
                        o_maxpool_ready <= sel_max;
                        o_avepool_ready <= sel_ave;
                        o_op_start      <= 1'b1;
                        state           <= S_WAIT_OP;
                    end
                end
                S_WAIT_OP: if (eng_valid) begin
                    prog <= prog_next;
                    if (ch_done) begin  // Drop ready with op_done
                        o_conv_ready    <= 1'b0;
                        o_maxpool_ready <= 1'b0;
                        o_avepool_ready <= 1'b0;
                        o_op_done       <= 1'b1;
                    end
                end
                S_FINISH: if (i_irq_clr) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
            if (cmd_step) begin  // Next-command decision
                cmd_done <= cmd_done + 1'b1;
                state    <= last_cmd ? S_FINISH : S_COLLECT;
            end
            if (cmd_step && last_cmd) begin
                o_irq    <= 1'b1;  // Held until cleared
                o_op_run <= 1'b0;
            end else if (i_irq_clr) begin
                o_irq <= 1'b0;
            end
        end
    end

endmodule

//--- csb/dma_port_ctrl.sv
`timescale 1ns/1ps

module dma_port_ctrl (
    input  logic    clk,
    input  logic    rst_n,
    cmd_desc_if.mon desc,
    input  logic    i_op_start,
    input  logic    i_op_done,
    output logic    o_p0_rd_en,
    output logic    o_p1_rd_en,
    output logic    o_p2_rd_en,
    output logic    o_p3_rd_en
);
    import csb_pkg::*;

    logic [3:0] rd_en;  // One bit per port, bit n is port n

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_en <= '0;
        end else if (i_op_done) begin
            rd_en <= '0;  // All ports off once the op ends
        end else if (i_op_start) begin
            case (desc.op_type)
                OP_CONV1X1:     rd_en <= 4'b1100;  // Ports 2 and 3
                OP_CONV3X3,
                OP_MAXPOOL3X3,
                OP_AVEPOOL13X13: rd_en <= 4'b0011;  // Ports 0 and 1
                OP_CONV3X3_1X1: rd_en <= 4'b1111;  // Both conv stages
                default:        rd_en <= '0;
            endcase
        end
    end

    assign o_p0_rd_en = rd_en[0];
    assign o_p1_rd_en = rd_en[1];
    assign o_p2_rd_en = rd_en[2];
    assign o_p3_rd_en = rd_en[3];

endmodule

//--- files.f
common/csb_pkg.sv
common/cmd_desc_if.sv
csb/cmd_fifo.sv
csb/cmd_parser.sv
csb/csb_sequencer.sv
csb/dma_port_ctrl.sv
hdl/csb_regs.sv
hdl/csb_top.sv
verification/tb_clkgen.sv
verification/csb_tb.sv

//--- hdl/csb_regs.sv
`timescale 1ns/1ps

module csb_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_reg_we,
    input  logic [1:0]                i_reg_addr,
    input  logic [15:0]               i_reg_wdata,
    output logic                      o_start,
    output logic                      o_irq_clr,
    output logic [csb_pkg::CNT_W-1:0] o_cmd_count
);
    import csb_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_start     <= 1'b0;
            o_irq_clr   <= 1'b0;
            o_cmd_count <= '0;
        end else begin
            o_start   <= 1'b0;  // Control bits self-clear
            o_irq_clr <= 1'b0;
            if (i_reg_we) begin
                case (i_reg_addr)
                    REG_CTRL: begin
                        o_start   <= i_reg_wdata[0];
                        o_irq_clr <= i_reg_wdata[1];
                    end
                    REG_CMD_COUNT: o_cmd_count <= i_reg_wdata;  // Commands per batch
                    default: ;  // Unmapped, ignored
                endcase
            end
        end
    end

endmodule

//--- hdl/csb_top.sv
`timescale 1ns/1ps

module csb_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_reg_we,
    input  logic [1:0]                i_reg_addr,
    input  logic [15:0]               i_reg_wdata,
    input  logic                      i_cmd_wr,
    input  logic [csb_pkg::CMD_W-1:0] i_cmd_wdata,
    output logic                      o_cmd_full,
    input  logic                      i_conv_valid,
    input  logic                      i_maxpool_valid,
    input  logic                      i_avepool_valid,
    output logic                      o_conv_ready,
    output logic                      o_maxpool_ready,
    output logic                      o_avepool_ready,
    output csb_pkg::op_type_e         o_op_type,
    output logic [15:0]               o_op_num,
    output logic [csb_pkg::CMD_W-1:0] o_weight_addr,
    output logic [csb_pkg::CMD_W-1:0] o_data_addr,
    output logic [csb_pkg::CMD_W-1:0] o_wb_addr,
    output logic                      o_op_run,
    output logic                      o_p0_rd_en,
    output logic                      o_p1_rd_en,
    output logic                      o_p2_rd_en,
    output logic                      o_p3_rd_en,
    output logic                      o_irq
);
    import csb_pkg::*;

    logic             start;
    logic             irq_clr;
    logic [CNT_W-1:0] cmd_count;
    logic [CMD_W-1:0] fifo_rdata;
    logic             fifo_empty;
    logic             fifo_rd;
    logic             collect;
    logic             op_start;
    logic             op_done;

    cmd_desc_if desc_if ();  // Parser to sequencer and port control

    csb_regs csb_regs_i (.clk, .rst_n, .i_reg_we, .i_reg_addr, .i_reg_wdata,
                         .o_start(start), .o_irq_clr(irq_clr), .o_cmd_count(cmd_count));

    cmd_fifo cmd_fifo_i (.clk, .rst_n, .i_wr(i_cmd_wr), .i_wdata(i_cmd_wdata), .i_rd(fifo_rd),
                         .o_rdata(fifo_rdata), .o_empty(fifo_empty), .o_full(o_cmd_full));

    cmd_parser cmd_parser_i (.clk, .rst_n, .i_collect(collect), .i_fifo_rdata(fifo_rdata),
                             .i_fifo_empty(fifo_empty), .o_fifo_rd(fifo_rd), .desc(desc_if));

    csb_sequencer csb_sequencer_i (
        .clk, .rst_n, .i_start(start), .i_irq_clr(irq_clr), .i_cmd_count(cmd_count),
        .o_collect(collect), .desc(desc_if), .i_conv_valid, .i_maxpool_valid,
        .i_avepool_valid, .o_conv_ready, .o_maxpool_ready, .o_avepool_ready,
        .o_op_start(op_start), .o_op_done(op_done), .o_op_run, .o_irq);

    dma_port_ctrl dma_port_ctrl_i (.clk, .rst_n, .desc(desc_if), .i_op_start(op_start),
                                   .i_op_done(op_done), .o_p0_rd_en, .o_p1_rd_en,
                                   .o_p2_rd_en, .o_p3_rd_en);

    // Decoded fields of the current command
    assign o_op_type     = desc_if.op_type;
    assign o_op_num      = desc_if.op_num;
    assign o_weight_addr = desc_if.weight_addr;
    assign o_data_addr   = desc_if.data_addr;
    assign o_wb_addr     = desc_if.wb_addr;

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the sequencer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

if ! verilator --binary --timing -f files.f --top-module csb_tb -o csb_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/csb_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi
cat "$LOG"

if grep -qx "Testbench passed" "$LOG"; then
    exit 0
fi
exit 1

//--- verification/csb_tb.sv
`timescale 1ns/1ps

module csb_tb;
    import csb_pkg::*;

    localparam int N_CMDS     = 11;
    localparam int N_FIRST    = 5;   // Batch 1 is preloaded before start
    localparam int HEAD_WORDS = FIFO_DEPTH - N_FIRST * CMD_WORDS;  // Tops the FIFO up to full
    localparam int MAX_PULSES = 5;   // o_channel_size up to 80
    localparam int MAX_GAP    = 6;   // Engine cycles between valids
    localparam int WR_GAP     = 12;  // Host cycles between words in batch 2
    localparam int TIMEOUT    = N_CMDS * (CMD_WORDS * (WR_GAP + 2)
                                + MAX_PULSES * (MAX_GAP + 1) + 20) + 200;
    localparam logic [31:0] SEED = 32'h2c08_5141;
    localparam int OPS [N_CMDS] = '{1, 2, 3, 4, 5, 0, 4, 6, 3, 5, 1};  // 0 and 6 skipped

    typedef struct packed {
        op_type_e    op;
        logic [15:0] op_num;
        logic [31:0] waddr;
        logic [31:0] daddr;
        logic [31:0] wbaddr;
        logic [2:0]  eng;     // {ave, max, conv}
        logic [3:0]  ports;   // Bit n is port n
        int          pulses;
    } exp_t;

    logic                       clk, rst_n;
    logic                       reg_we, cmd_wr, cmd_full;
    logic [1:0]                 reg_addr;
    logic [15:0]                reg_wdata, op_num;
    logic [CMD_W-1:0]           cmd_wdata, waddr, daddr, wb_addr;
    logic                       conv_valid, maxpool_valid, avepool_valid;
    logic                       conv_ready, maxpool_ready, avepool_ready;
    logic                       op_run, p0_en, p1_en, p2_en, p3_en, irq;
    op_type_e                   op_type;
    logic [CMD_W*CMD_WORDS-1:0] cmds [N_CMDS];  // Word k at bits k*32
    logic                       pulse_drv;      // Valid driven to the ready engine
    int                         sent_total, cycles, gap, errors, tests, failed;

    tb_clkgen tb_clkgen_i (.clk, .rst_n);

    csb_top csb_top_i (
        .clk, .rst_n, .i_reg_we(reg_we), .i_reg_addr(reg_addr), .i_reg_wdata(reg_wdata),
        .i_cmd_wr(cmd_wr), .i_cmd_wdata(cmd_wdata), .o_cmd_full(cmd_full),
        .i_conv_valid(conv_valid), .i_maxpool_valid(maxpool_valid),
        .i_avepool_valid(avepool_valid), .o_conv_ready(conv_ready),
        .o_maxpool_ready(maxpool_ready), .o_avepool_ready(avepool_ready),
        .o_op_type(op_type), .o_op_num(op_num), .o_weight_addr(waddr), .o_data_addr(daddr),
        .o_wb_addr(wb_addr), .o_op_run(op_run), .o_p0_rd_en(p0_en), .o_p1_rd_en(p1_en),
        .o_p2_rd_en(p2_en), .o_p3_rd_en(p3_en), .o_irq(irq));

    // Expected outcome of one command from the word layout
    function automatic exp_t expect_cmd(input logic [CMD_W*CMD_WORDS-1:0] cmd);
        exp_t        e;
        logic [15:0] o_ch;
        e.op     = op_type_e'(cmd[2:0]);
        e.op_num = cmd[2*CMD_W+16 +: 16];
        e.waddr  = cmd[3*CMD_W +: CMD_W];
        e.daddr  = cmd[4*CMD_W +: CMD_W];
        e.wbaddr = cmd[5*CMD_W +: CMD_W];
        o_ch     = cmd[CMD_W+16 +: 16];  // Output channel size
        case (cmd[2:0])
            3'd1:    {e.eng, e.ports} = {3'b001, 4'b1100};
            3'd2:    {e.eng, e.ports} = {3'b001, 4'b0011};
            3'd3:    {e.eng, e.ports} = {3'b001, 4'b1111};
            3'd4:    {e.eng, e.ports} = {3'b010, 4'b0011};
            3'd5:    {e.eng, e.ports} = {3'b100, 4'b0011};
            default: {e.eng, e.ports} = '0;  // Skipped op
        endcase
        e.pulses = (int'(o_ch) + CH_STEP - 1) / CH_STEP;
        if (e.pulses == 0)
            e.pulses = 1;  // Size 0 still needs one valid
        return e;
    endfunction

    function automatic logic [CMD_W*CMD_WORDS-1:0] make_cmd(input int op, input int idx);
        logic [CMD_W*CMD_WORDS-1:0] cmd;
        for (int k = 0; k < CMD_WORDS; k++)
            cmd[k*CMD_W +: CMD_W] = $urandom();
        cmd[2:0]            = 3'(op);
        cmd[CMD_W+16 +: 16] = 16'($urandom_range(MAX_PULSES * CH_STEP, 0));
        cmd[5*CMD_W +: 8]   = 8'(idx);  // Unique wb address per command
        return cmd;
    endfunction

    task automatic check_op(input string name, input op_type_e got, input op_type_e exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic inspect_levels(input logic [2:0] eng, input logic [3:0] ports, input bit pt);
        check_bit("o_conv_ready", conv_ready, eng[0]);
        check_bit("o_maxpool_ready", maxpool_ready, eng[1]);
        check_bit("o_avepool_ready", avepool_ready, eng[2]);
        if (pt) begin  // Ports lag ready by one cycle
            check_bit("o_p0_rd_en", p0_en, ports[0]);
            check_bit("o_p1_rd_en", p1_en, ports[1]);
            check_bit("o_p2_rd_en", p2_en, ports[2]);
            check_bit("o_p3_rd_en", p3_en, ports[3]);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        if (errors != err0)
            failed++;
        $display("Test %s: %s", name, errors == err0 ? "ok" : "FAILED");
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_we    = 1'b0;
    endtask

    task automatic push_cmd(input int idx, input int lo, input int hi, input int max_gap);
        for (int k = lo; k < hi; k++) begin
            repeat ($urandom_range(max_gap, 0)) @(negedge clk);
            while (cmd_full)
                @(negedge clk);  // Hold the word while the FIFO is full
            cmd_wr    = 1'b1;
            cmd_wdata = cmds[idx][k*CMD_W +: CMD_W];
            @(negedge clk);
            cmd_wr    = 1'b0;
        end
    endtask

    // Head words of batch 2 top the FIFO up, then one more word must be dropped
    task automatic fill_fifo();
        int err0;
        err0 = errors;
        check_bit("o_cmd_full", cmd_full, 1'b0);
        push_cmd(N_FIRST, 0, HEAD_WORDS, 0);
        check_bit("o_cmd_full", cmd_full, 1'b1);
        cmd_wr    = 1'b1;
        cmd_wdata = ~cmds[0][CMD_W-1:0];  // Would land on the first word of cmd 0
        @(negedge clk);
        cmd_wr    = 1'b0;
        check_bit("o_cmd_full", cmd_full, 1'b1);
        report_test("fifo full", err0);
    endtask

    // Engine model with valids at random gaps and noise on idle engines
    task automatic drive_engine();
        logic [2:0] rdy;
        conv_valid    = 1'b0;
        maxpool_valid = 1'b0;
        avepool_valid = 1'b0;
        pulse_drv     = 1'b0;
        forever begin
            @(negedge clk);
            rdy       = {avepool_ready, maxpool_ready, conv_ready};
            pulse_drv = 1'b0;
            if (rdy == '0) begin
                gap = $urandom_range(MAX_GAP, 1);  // First valid never in the ready cycle
            end else if (gap == 0) begin
                pulse_drv = 1'b1;
                gap       = $urandom_range(MAX_GAP, 0);
            end else begin
                gap = gap - 1;
            end
            {avepool_valid, maxpool_valid, conv_valid} = (rdy & {3{pulse_drv}})
                                                       | (~rdy & 3'($urandom_range(7, 0)));
        end
    endtask

    task automatic follow_cmd(input int idx);
        exp_t e;
        int   err0;
        int   base;
        bit   first;
        e     = expect_cmd(cmds[idx]);
        err0  = errors;
        first = 1'b1;
        if (e.eng == '0) begin
            while (wb_addr !== e.wbaddr)
                @(negedge clk);  // Skipped op still shows its fields
        end else begin
            while ({avepool_ready, maxpool_ready, conv_ready} == '0)
                @(negedge clk);
        end
        base = sent_total;
        check_op("o_op_type", op_type, e.op);
        check_word("o_op_num", 32'(op_num), 32'(e.op_num));
        check_word("o_weight_addr", waddr, e.waddr);
        check_word("o_data_addr", daddr, e.daddr);
        check_word("o_wb_addr", wb_addr, e.wbaddr);
        check_bit("o_op_run", op_run, 1'b1);
        check_bit("o_irq", irq, 1'b0);  // Batch not done yet
        if (e.eng == '0) begin
            repeat (4) begin  // Through issue and the port cycle after it
                inspect_levels(3'b000, 4'b0000, 1'b1);
                @(negedge clk);
            end
        end else begin
            while (sent_total - base < e.pulses) begin
                inspect_levels(e.eng, e.ports, !first);
                first = 1'b0;
                @(negedge clk);
            end
            inspect_levels(3'b000, e.ports, 1'b1);  // Ready off with the last valid
            @(negedge clk);
            inspect_levels(3'b000, 4'b0000, 1'b1);
        end
        report_test($sformatf("cmd %0d op %0d", idx, OPS[idx]), err0);
    endtask

    task automatic close_batch(input string name);
        int err0;
        err0 = errors;
        while (!irq)
            @(negedge clk);
        check_bit("o_op_run", op_run, 1'b0);
        repeat (4) begin
            @(negedge clk);
            check_bit("o_irq", irq, 1'b1);  // Sticky
        end
        write_reg(REG_CTRL, 16'h0002);
        @(negedge clk);
        check_bit("o_irq", irq, 1'b0);
        report_test(name, err0);
    endtask

    // Accepted valids and the run limit are counted on the active edge
    always @(posedge clk) begin
        if (pulse_drv)
            sent_total = sent_total + 1;
        cycles = cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("Timeout, the run was still busy after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED));
        reg_we    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        cmd_wr    = 1'b0;
        cmd_wdata = '0;
        for (int i = 0; i < N_CMDS; i++)
            cmds[i] = make_cmd(OPS[i], i);
        fork
            drive_engine();
        join_none
        @(posedge rst_n);
        @(negedge clk);
        for (int i = 0; i < N_FIRST; i++)
            push_cmd(i, 0, CMD_WORDS, 0);  // Whole batch waits in the FIFO
        fill_fifo();
        write_reg(REG_CMD_COUNT, 16'(N_FIRST));
        write_reg(REG_CTRL, 16'h0001);
        for (int i = 0; i < N_FIRST; i++)
            follow_cmd(i);
        close_batch("irq batch 1");
        write_reg(REG_CMD_COUNT, 16'(N_CMDS - N_FIRST));
        write_reg(REG_CTRL, 16'h0001);
        fork  // Words of the second batch trickle in after start
            for (int i = N_FIRST; i < N_CMDS; i++)
                push_cmd(i, (i == N_FIRST) ? HEAD_WORDS : 0, CMD_WORDS, WR_GAP);
            for (int j = N_FIRST; j < N_CMDS; j++)
                follow_cmd(j);
        join
        close_batch("irq batch 2");
        $display("Tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- verification/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF       = 20;  // 40 ns period
    localparam int RST_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #HALF clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;  // Released away from the active edge
    end

endmodule
